/* all.f */
+incdir+include
src/ex_op_pkg.sv
src/ex_pipe_pkg.sv
src/ex_op_decode.sv
src/rnn_spr_bank.sv
src/ex_alu.sv
src/ex_dotp_mult.sv
src/ex_wb_select.sv
src/ex_stage_top.sv
verif/tb_clk_gen.sv
verif/tb_ex_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing -f all.f --top-module tb_ex_stage \
        -o tb_ex_stage_sim 2>&1 && ./obj_dir/tb_ex_stage_sim 2>&1)
echo "$out"

echo "$out" | grep -q "^Test passed$" && exit 0 || exit 1

/* verif/tb_ex_stage.sv */
// Execute stage testbench
// Table of issue, LSU and WB stimulus with expected port values,
// applied one row per clock and checked mid-cycle

`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module tb_ex_stage
  import ex_op_pkg::*;
  import ex_pipe_pkg::*;
();

  localparam int NUM_ROWS   = 80;
  localparam int CLK_PERIOD = 100;

  typedef struct packed {
    ex_issue_t   issue;
    lsu_bundle_t lsu;
    logic        wb_ready;
    wr_port_t    exp_fw;
    wr_port_t    exp_wb;      // Seen on wb one row later
    logic        exp_br;
    logic        exp_valid;
    logic        exp_ready;
    logic        exp_cl;
  } row_t;

  logic             clk;
  logic             rst_n;
  ex_issue_t        issue;
  lsu_bundle_t      lsu;
  logic             wb_ready;
  wr_port_t         fw;
  wr_port_t         wb;
  logic [`XLEN-1:0] jump_target;
  logic             branch_decision;
  logic             compute_load;
  logic             ex_ready;
  logic             ex_valid;

  row_t   rows [NUM_ROWS];
  int     n_rows  = 0;
  int     cur_row = 0;
  integer seed    = 91;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage_top i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue),
    .lsu_i             (lsu),
    .wb_ready_i        (wb_ready),
    .fw_o              (fw),
    .wb_o              (wb),
    .jump_target_o     (jump_target),
    .branch_decision_o (branch_decision),
    .compute_load_o    (compute_load),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  ////////////////////////////////////////////////////////////////////
  // Reference arithmetic
  ////////////////////////////////////////////////////////////////////

  function automatic logic cmp_ref(input alu_op_e op, input logic [`XLEN-1:0] a,
                                   input logic [`XLEN-1:0] b);
    logic lt_s;
    lt_s = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);   // Sign decides first
    case (op)
      ALU_EQ:          return a == b;
      ALU_NE:          return a != b;
      ALU_LT, ALU_SLT: return lt_s;
      ALU_GE:          return !lt_s;
      ALU_SLTU:        return a < b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] alu_ref(input alu_op_e op, input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    int               sh;
    logic [`XLEN-1:0] fill;
    sh   = {27'd0, b[4:0]};
    fill = {`XLEN{a[`XLEN-1]}} << (`XLEN - sh);   // Sign bits shifted in by SRA
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      ALU_SRA: return (a >> sh) | fill;
      default: return {{(`XLEN-1){1'b0}}, cmp_ref(op, a, b)};
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] mult_ref(input mult_op_e op, input logic [`XLEN-1:0] a,
                                                input logic [`XLEN-1:0] b,
                                                input logic [`XLEN-1:0] c);
    int acc;
    int pa;
    int pb;
    acc = c;
    if (op == MULT_DOT8) begin
      for (int i = 0; i < 4; i++) begin
        pa  = {{24{a[8*i+7]}}, a[8*i +: 8]};
        pb  = {{24{b[8*i+7]}}, b[8*i +: 8]};
        acc = acc + pa * pb;
      end
    end else if (op == MULT_DOT16) begin
      for (int j = 0; j < 2; j++) begin
        pa  = {{16{a[16*j+15]}}, a[16*j +: 16]};
        pb  = {{16{b[16*j+15]}}, b[16*j +: 16]};
        acc = acc + pa * pb;
      end
    end else if (op == MULT_MAC) begin
      acc = a * b + c;
    end else begin
      acc = a * b;
    end
    return acc;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////////////////////////////////

  function automatic logic [`XLEN-1:0] rand_word();
    return $random(seed);
  endfunction

  function automatic lsu_bundle_t plain_lsu();
    lsu_bundle_t l;
    l       = '0;
    l.ready = 1'b1;
    l.rdata = rand_word();
    return l;
  endfunction

  task automatic push_row(input ex_issue_t iss, input lsu_bundle_t l, input logic wr);
    if (n_rows >= NUM_ROWS) begin
      $display("Stimulus table is full at %0d rows", n_rows);
      $display("Test failed");
      $fatal(1, "table overflow");
    end else begin
      rows[n_rows]          = '0;
      rows[n_rows].issue    = iss;
      rows[n_rows].lsu      = l;
      rows[n_rows].wb_ready = wr;
      n_rows++;
    end
  endtask

  // Register operands and a random forward write enable
  task automatic add_alu(input alu_op_e op, input logic same_ops);
    ex_issue_t        iss;
    logic [`XLEN-1:0] w;
    iss           = '0;
    w             = rand_word();
    iss.alu_en    = 1'b1;
    iss.alu_op    = op;
    iss.op_a      = rand_word();
    iss.op_b      = same_ops ? iss.op_a : rand_word();
    iss.op_c      = rand_word();
    iss.alu_we    = w[0];
    iss.alu_waddr = w[13:8];
    push_row(iss, plain_lsu(), 1'b1);
  endtask

  task automatic add_mult(input mult_op_e op, input logic alu_en, input logic csr);
    ex_issue_t        iss;
    logic [`XLEN-1:0] w;
    iss            = '0;
    w              = rand_word();
    iss.mult_en    = 1'b1;
    iss.mult_op    = op;
    iss.mult_a     = rand_word();
    iss.mult_b     = rand_word();
    iss.mult_c     = rand_word();
    iss.alu_en     = alu_en;
    iss.op_a       = rand_word();
    iss.op_b       = rand_word();
    iss.csr_access = csr;
    iss.csr_rdata  = rand_word();
    iss.alu_we     = 1'b1;
    iss.alu_waddr  = w[5:0];
    push_row(iss, plain_lsu(), 1'b1);
  endtask

  task automatic add_load(input logic err, input wspr_tag_t tw, input aspr_tag_t ta);
    ex_issue_t        iss;
    lsu_bundle_t      l;
    logic [`XLEN-1:0] w;
    iss          = '0;
    w            = rand_word();
    iss.lsu_en   = 1'b1;
    iss.rf_we    = 1'b1;
    iss.rf_waddr = w[5:0];
    l            = plain_lsu();
    l.err        = err;
    l.tosprw     = tw;
    l.tospra     = ta;
    push_row(iss, l, 1'b1);
  endtask

  // Load-and-compute on weight 2 and activation 1
  task automatic add_dot_spr(input mult_op_e op);
    ex_issue_t        iss;
    logic [`XLEN-1:0] w;
    iss           = '0;
    w             = rand_word();
    iss.alu_en    = 1'b1;
    iss.alu_op    = ALU_ADD;
    iss.op_a      = rand_word();
    iss.op_b      = rand_word();
    iss.alu_we    = 1'b1;
    iss.alu_waddr = w[5:0];
    iss.mult_en   = 1'b1;
    iss.mult_op   = op;
    iss.mult_a    = rand_word();
    iss.mult_b    = rand_word();
    iss.mult_c    = rand_word();
    iss.dot_spr   = 1'b1;
    iss.spr_wsel  = 2'd2;
    iss.spr_asel  = 1'b1;
    iss.rf_we     = 1'b1;
    iss.rf_waddr  = w[13:8];
    push_row(iss, plain_lsu(), 1'b1);
  endtask

  task automatic add_stall(input logic branch, input logic wr);
    ex_issue_t   iss;
    lsu_bundle_t l;
    iss              = '0;
    iss.alu_en       = 1'b1;
    iss.alu_op       = ALU_EQ;
    iss.op_a         = rand_word();
    iss.op_b         = iss.op_a;
    iss.branch_in_ex = branch;
    l                = plain_lsu();
    l.rdata          = rows[n_rows-1].lsu.rdata;   // Keep WB data steady
    push_row(iss, l, wr);
  endtask

  task automatic build_table();
    for (int k = 0; k < 3; k++) begin
      for (int op = 0; op < 14; op++) begin
        add_alu(alu_op_e'(op[3:0]), k == 2);
      end
    end
    for (int k = 0; k < 3; k++) begin
      for (int op = 0; op < 4; op++) begin
        add_mult(mult_op_e'(op[1:0]), k[0], 1'b0);
      end
    end
    add_mult(MULT_MAC, 1'b1, 1'b1);   // CSR wins over mult
    add_mult(MULT_DOT8, 1'b0, 1'b1);
    add_mult(MULT_MUL, 1'b1, 1'b1);
    // Plain load followed by a faulting one
    add_load(1'b0, '0, '0);
    add_load(1'b1, '0, '0);
    push_row('0, plain_lsu(), 1'b1);
    // Fill weight 2 and activation 1 before the dot products
    add_load(1'b0, 3'b101, '0);
    add_load(1'b0, '0, 2'b11);
    push_row('0, plain_lsu(), 1'b1);
    add_dot_spr(MULT_DOT8);
    push_row('0, plain_lsu(), 1'b1);
    add_dot_spr(MULT_DOT16);
    // Back-pressure from WB behind a load
    add_load(1'b0, '0, '0);
    add_stall(1'b0, 1'b0);
    add_stall(1'b0, 1'b0);
    add_stall(1'b1, 1'b0);
    add_stall(1'b0, 1'b1);
    push_row('0, plain_lsu(), 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Expected values from the stage timing rules
  ////////////////////////////////////////////////////////////////////

  task automatic compute_expected();
    ex_issue_t              iss;
    lsu_bundle_t            l;
    wr_port_t               fwp;
    logic                   valid;
    logic [`XLEN-1:0]       ma;
    logic [`XLEN-1:0]       mb;
    logic [`XLEN-1:0]       mres;
    logic [`XLEN-1:0]       ares;
    logic                   we_q;
    logic [`REG_ADDR_W-1:0] waddr_q;
    wspr_tag_t              tw_q;
    aspr_tag_t              ta_q;
    logic                   dot_q;
    logic [`XLEN-1:0]       mres_q;
    logic [`XLEN-1:0]       wmem [`NUM_WSPR];
    logic [`XLEN-1:0]       amem [`NUM_ASPR];
    we_q    = 1'b0;
    waddr_q = '0;
    tw_q    = '0;
    ta_q    = '0;
    dot_q   = 1'b0;
    mres_q  = '0;
    foreach (wmem[i]) wmem[i] = '0;
    foreach (amem[i]) amem[i] = '0;
    for (int r = 0; r < n_rows; r++) begin
      iss = rows[r].issue;
      l   = rows[r].lsu;
      ma  = iss.mult_a;
      mb  = iss.mult_b;
      if (iss.dot_spr && (iss.mult_op == MULT_DOT8 || iss.mult_op == MULT_DOT16)) begin
        ma = amem[iss.spr_asel];
        mb = wmem[iss.spr_wsel];
      end
      mres      = mult_ref(iss.mult_op, ma, mb, iss.mult_c);
      ares      = alu_ref(iss.alu_op, iss.op_a, iss.op_b);
      fwp.we    = iss.alu_we;
      fwp.waddr = iss.alu_waddr;
      if (iss.dot_spr && iss.mult_en) fwp.wdata = ares;
      else if (iss.csr_access)        fwp.wdata = iss.csr_rdata;
      else if (iss.mult_en)           fwp.wdata = mres;
      else if (iss.alu_en)            fwp.wdata = ares;
      else                            fwp.wdata = '0;
      valid = (iss.alu_en | iss.mult_en | iss.csr_access | iss.lsu_en) & l.ready
              & rows[r].wb_ready;
      rows[r].exp_fw    = fwp;
      rows[r].exp_br    = cmp_ref(iss.alu_op, iss.op_a, iss.op_b);
      rows[r].exp_valid = valid;
      rows[r].exp_ready = (l.ready & rows[r].wb_ready) | iss.branch_in_ex;
      rows[r].exp_cl    = iss.dot_spr & iss.mult_en;
      // WB port during this row belongs to the previous one
      if (r > 0) begin
        rows[r-1].exp_wb.we    = we_q;
        rows[r-1].exp_wb.waddr = waddr_q;
        rows[r-1].exp_wb.wdata = dot_q ? mres_q : l.rdata;
      end
      // Clock edge updates with {index, enable} tags
      if (we_q && tw_q[0]) wmem[tw_q[2:1]] = l.rdata;
      if (we_q && ta_q[0]) amem[ta_q[1]] = l.rdata;
      mres_q = mres;
      if (valid) begin
        we_q  = iss.rf_we & ~l.err;
        tw_q  = l.tosprw;
        ta_q  = l.tospra;
        dot_q = iss.dot_spr;
        if (we_q) waddr_q = iss.rf_waddr;
      end else if (rows[r].wb_ready) begin
        we_q = 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////

  task automatic check_port(input string name, input wr_port_t act_v, input wr_port_t exp_v);
    if (act_v !== exp_v) begin
      $display("ERR %s row %0d: got we=%h waddr=%h wdata=%h, expected we=%h waddr=%h wdata=%h",
               name, cur_row, act_v.we, act_v.waddr, act_v.wdata,
               exp_v.we, exp_v.waddr, exp_v.wdata);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] act_v,
                            input logic [`XLEN-1:0] exp_v);
    if (act_v !== exp_v) begin
      $display("ERR %s row %0d: got %h expected %h", name, cur_row, act_v, exp_v);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic act_v, input logic exp_v);
    if (act_v !== exp_v) begin
      $display("ERR %s row %0d: got %h expected %h", name, cur_row, act_v, exp_v);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus loop and watchdog
  ////////////////////////////////////////////////////////////////////

  initial begin
    issue    <= '0;
    lsu      <= '0;
    wb_ready <= 1'b0;
    build_table();
    compute_expected();
    wait (rst_n === 1'b1);
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk);
      issue    <= rows[r].issue;
      lsu      <= rows[r].lsu;
      wb_ready <= rows[r].wb_ready;
      @(negedge clk);   // Outputs settled mid-cycle
      cur_row = r;
      check_port("fw", fw, rows[r].exp_fw);
      check_word("jump_target", jump_target, rows[r].issue.op_c);
      check_bit("branch_decision", branch_decision, rows[r].exp_br);
      check_bit("ex_valid", ex_valid, rows[r].exp_valid);
      check_bit("ex_ready", ex_ready, rows[r].exp_ready);
      check_bit("compute_load", compute_load, rows[r].exp_cl);
      if (r > 0) check_port("wb", wb, rows[r-1].exp_wb);
    end
    $display("Test passed");
    $finish;
  end

  // Reset plus one cycle per row and some margin
  initial begin
    #((NUM_ROWS + 10) * CLK_PERIOD);
    $display("Watchdog expired before all table rows were applied");
    $display("Test failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
// Testbench clock and reset
// 100 ns clock, active low reset held for the first two cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the DUT sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #(HALF_PERIOD) rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* src/ex_stage_top.sv */
// Execute stage top level
// RISC-V EX stage with ALU, dot-product multiplier and RNN special
// registers, driving the forward and writeback register file ports

`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module ex_stage_top
  import ex_op_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  ex_issue_t        issue_i,
  input  lsu_bundle_t      lsu_i,
  input  logic             wb_ready_i,
  output wr_port_t         fw_o,
  output wr_port_t         wb_o,
  output logic [`XLEN-1:0] jump_target_o,
  output logic             branch_decision_o,
  output logic             compute_load_o,
  output logic             ex_ready_o,
  output logic             ex_valid_o
);

  alu_op_e          alu_op;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_res;
  logic             alu_cmp;
  mult_op_e         mult_op;
  logic [`XLEN-1:0] mult_a;
  logic [`XLEN-1:0] mult_b;
  logic [`XLEN-1:0] mult_c;
  logic [`XLEN-1:0] mult_res;
  logic [`XLEN-1:0] wspr;
  logic [`XLEN-1:0] aspr;
  ex_sel_t          sel;
  spr_tags_t        spr_tags;

  assign jump_target_o     = issue_i.op_c;
  assign branch_decision_o = alu_cmp;
  assign compute_load_o    = issue_i.dot_spr & issue_i.mult_en;

  //////////////////////////////////////////////////////////////////////
  // Decode and SPRs
  //////////////////////////////////////////////////////////////////////

  ex_op_decode i_decode (
    .issue_i   (issue_i),
    .wspr_i    (wspr),
    .aspr_i    (aspr),
    .alu_op_o  (alu_op),
    .alu_a_o   (alu_a),
    .alu_b_o   (alu_b),
    .mult_op_o (mult_op),
    .mult_a_o  (mult_a),
    .mult_b_o  (mult_b),
    .mult_c_o  (mult_c),
    .sel_o     (sel)
  );

  rnn_spr_bank i_spr_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en_i  (spr_tags.we),
    .tosprw_i (spr_tags.tosprw),
    .tospra_i (spr_tags.tospra),
    .rdata_i  (lsu_i.rdata),
    .wsel_i   (issue_i.spr_wsel),
    .asel_i   (issue_i.spr_asel),
    .wspr_o   (wspr),
    .aspr_o   (aspr)
  );

  //////////////////////////////////////////////////////////////////////
  // Execute units
  //////////////////////////////////////////////////////////////////////

  ex_alu i_alu (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_res),
    .cmp_o    (alu_cmp)
  );

  ex_dotp_mult i_mult (
    .op_i     (mult_op),
    .a_i      (mult_a),
    .b_i      (mult_b),
    .c_i      (mult_c),
    .result_o (mult_res)
  );

  // Write ports and pipeline control
  ex_wb_select i_wb_select (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue_i    (issue_i),
    .sel_i      (sel),
    .alu_res_i  (alu_res),
    .mult_res_i (mult_res),
    .lsu_i      (lsu_i),
    .wb_ready_i (wb_ready_i),
    .fw_o       (fw_o),
    .wb_o       (wb_o),
    .spr_tags_o (spr_tags),
    .ex_ready_o (ex_ready_o),
    .ex_valid_o (ex_valid_o)
  );

endmodule

`default_nettype wire

/* src/ex_wb_select.sv */
// Execute result select
// Forward and writeback port muxes, EX/WB pipeline register with
// the SPR load tags, and the ex_ready / ex_valid pipeline controls

`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module ex_wb_select
  import ex_pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  ex_issue_t        issue_i,
  input  ex_sel_t          sel_i,
  input  logic [`XLEN-1:0] alu_res_i,
  input  logic [`XLEN-1:0] mult_res_i,
  input  lsu_bundle_t      lsu_i,
  input  logic             wb_ready_i,
  output wr_port_t         fw_o,
  output wr_port_t         wb_o,
  output spr_tags_t        spr_tags_o,
  output logic             ex_ready_o,
  output logic             ex_valid_o
);

  logic                   lsu_we;
  logic                   we_q;
  logic [`REG_ADDR_W-1:0] waddr_q;
  wspr_tag_t              tosprw_q;
  aspr_tag_t              tospra_q;
  logic                   dot_spr_q;
  logic [`XLEN-1:0]       mult_res_q;   // Dot result for load-and-compute

  // Forward port, same cycle as issue
  always_comb begin
    fw_o.we    = issue_i.alu_we;
    fw_o.waddr = issue_i.alu_waddr;
    if (sel_i.csr_sel) begin
      fw_o.wdata = issue_i.csr_rdata;
    end else if (sel_i.mult_sel) begin
      fw_o.wdata = mult_res_i;
    end else if (sel_i.alu_sel) begin
      fw_o.wdata = alu_res_i;
    end else begin
      fw_o.wdata = '0;
    end
  end

  // A faulting load never reaches the register file
  assign lsu_we = issue_i.rf_we & ~lsu_i.err;

  //////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q      <= 1'b0;
      waddr_q   <= '0;
      tosprw_q  <= '0;
      tospra_q  <= '0;
      dot_spr_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_q      <= lsu_we;
      tosprw_q  <= lsu_i.tosprw;
      tospra_q  <= lsu_i.tospra;
      dot_spr_q <= issue_i.dot_spr;
      if (lsu_we) begin
        waddr_q <= issue_i.rf_waddr;
      end
    end else if (wb_ready_i) begin
      we_q <= 1'b0;   // Bubble, flush the slot
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mult_res_q <= '0;
    end else begin
      mult_res_q <= mult_res_i;
    end
  end

  // Writeback port
  assign wb_o.we    = we_q;
  assign wb_o.waddr = waddr_q;
  assign wb_o.wdata = dot_spr_q ? mult_res_q : lsu_i.rdata;

  assign spr_tags_o.we     = we_q;
  assign spr_tags_o.tosprw = tosprw_q;
  assign spr_tags_o.tospra = tospra_q;

  // Branches resolve in EX and do not wait on WB
  assign ex_ready_o = (lsu_i.ready & wb_ready_i) | issue_i.branch_in_ex;
  assign ex_valid_o = (issue_i.alu_en | issue_i.mult_en | issue_i.csr_access | issue_i.lsu_en)
                      & lsu_i.ready & wb_ready_i;

endmodule

`default_nettype wire

/* src/ex_dotp_mult.sv */
// Single cycle multiplier
// Plain multiply, multiply-accumulate and signed packed dot products
// on bytes and halfwords, all with the low word as result

`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module ex_dotp_mult
  import ex_op_pkg::*;
(
  input  mult_op_e         op_i,
  input  logic [`XLEN-1:0] a_i,
  input  logic [`XLEN-1:0] b_i,
  input  logic [`XLEN-1:0] c_i,    // Accumulator
  output logic [`XLEN-1:0] result_o
);

  logic [`XLEN-1:0]   prod;
  logic signed [15:0] byte_prod [`XLEN/8];
  logic signed [31:0] half_prod [`XLEN/16];
  logic [`XLEN-1:0]   dot8_sum;
  logic [`XLEN-1:0]   dot16_sum;

  assign prod = a_i * b_i;   // Low word only

  // Lane products
  always_comb begin
    for (int i = 0; i < `XLEN/8; i++) begin
      byte_prod[i] = 16'($signed(a_i[8*i +: 8])) * 16'($signed(b_i[8*i +: 8]));
    end
    for (int j = 0; j < `XLEN/16; j++) begin
      half_prod[j] = 32'($signed(a_i[16*j +: 16])) * 32'($signed(b_i[16*j +: 16]));
    end
  end

  // Reduction trees with sign extended lanes
  always_comb begin
    dot8_sum = c_i;
    for (int i = 0; i < `XLEN/8; i++) begin
      dot8_sum = dot8_sum + `XLEN'(byte_prod[i]);
    end
  end

  always_comb begin
    dot16_sum = c_i;
    for (int j = 0; j < `XLEN/16; j++) begin
      dot16_sum = dot16_sum + `XLEN'(half_prod[j]);
    end
  end

  always_comb begin
    case (op_i)
      MULT_MUL:   result_o = prod;
      MULT_MAC:   result_o = prod + c_i;
      MULT_DOT8:  result_o = dot8_sum;
      MULT_DOT16: result_o = dot16_sum;
      default:    result_o = prod;
    endcase
  end

endmodule

`default_nettype wire

/* src/ex_alu.sv */
// Integer ALU
// Add, subtract, logic, shifts, set-less-than and the branch compare

`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module ex_alu
  import ex_op_pkg::*;
(
  input  alu_op_e          op_i,
  input  logic [`XLEN-1:0] a_i,
  input  logic [`XLEN-1:0] b_i,
  output logic [`XLEN-1:0] result_o,
  output logic             cmp_o      // Branch taken for compare ops
);

  logic [$clog2(`XLEN)-1:0] shamt;
  logic                     eq;
  logic                     lt_s;
  logic                     lt_u;

  assign shamt = b_i[$clog2(`XLEN)-1:0];
  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);

  //////////////////////////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_EQ:   cmp_o = eq;
      ALU_NE:   cmp_o = ~eq;
      ALU_LT:   cmp_o = lt_s;
      ALU_GE:   cmp_o = ~lt_s;
      ALU_SLT:  cmp_o = lt_s;
      ALU_SLTU: cmp_o = lt_u;
      default:  cmp_o = 1'b0;   // Not a compare
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = a_i + b_i;
      ALU_SUB: result_o = a_i - b_i;
      ALU_AND: result_o = a_i & b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      ALU_SLL: result_o = a_i << shamt;
      ALU_SRL: result_o = a_i >> shamt;
      ALU_SRA: result_o = $signed(a_i) >>> shamt;
      // Compare group returns the flag as a word
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE: begin
        result_o = {{(`XLEN-1){1'b0}}, cmp_o};
      end
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/rnn_spr_bank.sv */
// RNN special register bank
// Four weight and two activation words, loaded from LSU read data
// in the writeback cycle and read by the current instruction

`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module rnn_spr_bank
  import ex_pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_en_i,     // Registered GPR write of the load
  input  wspr_tag_t        tosprw_i,
  input  aspr_tag_t        tospra_i,
  input  logic [`XLEN-1:0] rdata_i,
  input  wspr_idx_t        wsel_i,
  input  aspr_idx_t        asel_i,
  output logic [`XLEN-1:0] wspr_o,
  output logic [`XLEN-1:0] aspr_o
);

  logic [`NUM_WSPR-1:0][`XLEN-1:0] wspr_q;
  logic [`NUM_ASPR-1:0][`XLEN-1:0] aspr_q;

  wspr_idx_t wspr_widx;
  aspr_idx_t aspr_widx;

  // Tag is {index, enable}
  assign wspr_widx = tosprw_i[$clog2(`NUM_WSPR):1];
  assign aspr_widx = tospra_i[$clog2(`NUM_ASPR):1];

  //////////////////////////////////////////////////////////////////////
  // SPR write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wspr_q <= '0;
      aspr_q <= '0;
    end else begin
      if (wr_en_i && tosprw_i[0]) begin
        wspr_q[wspr_widx] <= rdata_i;
      end
      if (wr_en_i && tospra_i[0]) begin
        aspr_q[aspr_widx] <= rdata_i;
      end
    end
  end

  // Read port for the instruction in EX
  assign wspr_o = wspr_q[wsel_i];
  assign aspr_o = aspr_q[asel_i];

endmodule

`default_nettype wire

/* src/ex_op_decode.sv */
// Execute operand decode
// Steers ALU and multiplier operands, swaps in SPR words for
// load-and-compute dot products and picks the forward port owner

`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module ex_op_decode
  import ex_op_pkg::*;
  import ex_pipe_pkg::*;
(
  input  ex_issue_t        issue_i,
  input  logic [`XLEN-1:0] wspr_i,    // Weight word picked by spr_wsel
  input  logic [`XLEN-1:0] aspr_i,    // Activation word picked by spr_asel
  output alu_op_e          alu_op_o,
  output logic [`XLEN-1:0] alu_a_o,
  output logic [`XLEN-1:0] alu_b_o,
  output mult_op_e         mult_op_o,
  output logic [`XLEN-1:0] mult_a_o,
  output logic [`XLEN-1:0] mult_b_o,
  output logic [`XLEN-1:0] mult_c_o,
  output ex_sel_t          sel_o
);

  logic is_dot;
  logic use_spr;
  logic load_compute;

  assign is_dot       = (issue_i.mult_op == MULT_DOT8) || (issue_i.mult_op == MULT_DOT16);
  assign use_spr      = issue_i.dot_spr & is_dot;
  assign load_compute = issue_i.dot_spr & issue_i.mult_en;

  // ALU takes register operands as issued
  assign alu_op_o = issue_i.alu_op;
  assign alu_a_o  = issue_i.op_a;
  assign alu_b_o  = issue_i.op_b;

  // Activation on a, weight on b
  assign mult_op_o = issue_i.mult_op;
  assign mult_a_o  = use_spr ? aspr_i : issue_i.mult_a;
  assign mult_b_o  = use_spr ? wspr_i : issue_i.mult_b;
  assign mult_c_o  = issue_i.mult_c;

  // Forward port owner
  // CSR over mult over ALU, load-and-compute keeps the ALU result
  always_comb begin
    sel_o = '0;
    if (load_compute) begin
      sel_o.alu_sel = 1'b1;   // Dot result leaves through WB
    end else if (issue_i.csr_access) begin
      sel_o.csr_sel = 1'b1;
    end else if (issue_i.mult_en) begin
      sel_o.mult_sel = 1'b1;
    end else if (issue_i.alu_en) begin
      sel_o.alu_sel = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/ex_pipe_pkg.sv */
// Execute stage pipeline bundles
// Issue bundle from ID, LSU bundle, write ports and local selects

`default_nettype none

`include "ex_cfg.svh"

package ex_pipe_pkg;

  import ex_op_pkg::*;

  // SPR index and LSU tag types, tag is {index, enable}
  typedef logic [$clog2(`NUM_WSPR)-1:0] wspr_idx_t;
  typedef logic [$clog2(`NUM_ASPR)-1:0] aspr_idx_t;
  typedef logic [$clog2(`NUM_WSPR):0]   wspr_tag_t;
  typedef logic [$clog2(`NUM_ASPR):0]   aspr_tag_t;

  typedef struct packed {
    logic                   alu_en;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic [`XLEN-1:0]       op_c;          // Jump target
    logic                   mult_en;
    mult_op_e               mult_op;
    logic [`XLEN-1:0]       mult_a;
    logic [`XLEN-1:0]       mult_b;
    logic [`XLEN-1:0]       mult_c;
    logic                   csr_access;
    logic [`XLEN-1:0]       csr_rdata;
    logic [`REG_ADDR_W-1:0] alu_waddr;
    logic                   alu_we;
    logic                   rf_we;         // LSU write, goes to WB
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic                   lsu_en;
    logic                   branch_in_ex;
    logic                   dot_spr;       // Dot operands from SPRs
    wspr_idx_t              spr_wsel;
    aspr_idx_t              spr_asel;
  } ex_issue_t;

  typedef struct packed {
    logic [`XLEN-1:0] rdata;
    wspr_tag_t        tosprw;
    aspr_tag_t        tospra;
    logic             ready;
    logic             err;
  } lsu_bundle_t;

  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] waddr;
    logic [`XLEN-1:0]       wdata;
  } wr_port_t;

  // Forward port owner, one hot at most
  typedef struct packed {
    logic alu_sel;
    logic mult_sel;
    logic csr_sel;
  } ex_sel_t;

  // Registered SPR load tags
  typedef struct packed {
    logic      we;
    wspr_tag_t tosprw;
    aspr_tag_t tospra;
  } spr_tags_t;

endpackage

`default_nettype wire

/* src/ex_op_pkg.sv */
// Execute stage operation codes
// Opcode enums for the integer ALU and the dot-product multiplier

`default_nettype none

package ex_op_pkg;

  // ALU opcodes, the compare group drives the branch decision
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13
  } alu_op_e;

  // Multiplier opcodes
  typedef enum logic [1:0] {
    MULT_MUL   = 2'd0,  // Low word of a*b
    MULT_MAC   = 2'd1,  // a*b + c
    MULT_DOT8  = 2'd2,  // Four signed byte products plus c
    MULT_DOT16 = 2'd3   // Two signed halfword products plus c
  } mult_op_e;

endpackage

`default_nettype wire

/* include/ex_cfg.svh */
// Execute stage configuration
// Word width, register address width and RNN special register counts

`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Data path
`define XLEN        32

// Register file address, 32 GPRs plus FP and special space
`define REG_ADDR_W  6

// RNN extension special registers
`define NUM_WSPR    4   // Weight words
`define NUM_ASPR    2   // Activation words

`endif
